// File: dv/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker
   import fft_sample_pkg::*;
   import fft_twiddle_pkg::*;
(
   input  wire logic         clk,
   input  wire logic         reset,
   input  wire logic         exp_push,      // read strobed at this edge
   input  wire logic [7:0]   exp_test,
   input  wire cplx_sample_t exp_sample,
   input  wire twiddle_t     exp_twiddle,
   input  wire cplx_sample_t sample_out,
   input  wire twiddle_t     twiddle_out,
   input  wire logic         radix_valid,
   output int                value_errs,
   output int                pulse_errs,
   output int                checks_done
);

   typedef struct packed {
      logic [7:0]   test;
      cplx_sample_t sample;
      twiddle_t     twiddle;
   } expect_t;

   expect_t pending [$];   // reads still waiting for their pulse
   expect_t head;

   function automatic string test_name(input logic [7:0] id);
      case (id)
         8'h2:    return "bitrev_read";
         8'h3:    return "twiddle_regions";
         8'h4:    return "back_to_back";
         8'h5:    return "same_edge_write";
         default: return "unnamed";
      endcase
   endfunction

   task automatic compare_part(input string test, input string part,
                               input logic signed [31:0] expv,
                               input logic signed [31:0] actv);
      if (actv !== expv) begin
         value_errs++;
         $display("ERR %s %s expected %0d actual %0d at %0t", test, part, expv, actv, $time);
      end
   endtask

   // values seen here are the ones settled before this edge
   always @(posedge clk) begin
      if (reset) begin
         pending.delete();
         value_errs  = 0;
         pulse_errs  = 0;
         checks_done = 0;
      end else begin
         if (radix_valid && pending.size() == 0) begin
            pulse_errs++;
            $display("extra valid pulse at %0t with no read outstanding", $time);
         end else if (radix_valid) begin
            head = pending.pop_front();
            compare_part(test_name(head.test), "re", head.sample.re, sample_out.re);
            compare_part(test_name(head.test), "im", head.sample.im, sample_out.im);
            compare_part(test_name(head.test), "cos", head.twiddle.cos, twiddle_out.cos);
            compare_part(test_name(head.test), "sin", head.twiddle.sin, twiddle_out.sin);
            checks_done++;
         end else if (pending.size() != 0) begin
            pulse_errs++;
            $display("missing valid pulse at %0t for the read strobed one cycle earlier",
                     $time);
            head = pending.pop_front();
         end
         if (exp_push) begin
            pending.push_back({exp_test, exp_sample, exp_twiddle});
         end
      end
   end

endmodule

`default_nettype wire

// File: dv/fetch_props.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_props
   import fft_sample_pkg::*;
   import fft_twiddle_pkg::*;
(
   input wire logic         clk,
   input wire logic         reset,
   input wire logic         rd_en,
   input wire logic         radix_valid,
   input wire cplx_sample_t sample_out,
   input wire twiddle_t     twiddle_out
);

   int   fail_count;
   logic read_seen;   // output regs are x until the first strobe

   initial fail_count = 0;

   always_ff @(posedge clk) begin
      if (reset) begin
         read_seen <= 1'b0;
      end else if (rd_en) begin
         read_seen <= 1'b1;
      end
   end

   reset_clears_valid: assert property (@(posedge clk) reset |=> !radix_valid)
      else begin
         fail_count++;
         $error("radix_valid high in the cycle after reset");
      end

   // one pulse per strobe, one cycle late
   valid_follows_strobe: assert property (@(posedge clk) disable iff (reset)
      radix_valid == $past(rd_en))
      else begin
         fail_count++;
         $error("radix_valid does not match rd_en of the previous cycle");
      end

   outputs_hold_when_idle: assert property (@(posedge clk) disable iff (reset)
      (read_seen && !$past(rd_en)) |-> ($stable(sample_out) && $stable(twiddle_out)))
      else begin
         fail_count++;
         $error("sample_out or twiddle_out changed without a read strobe");
      end

endmodule

`default_nettype wire

// File: dv/fetch_trace.txt
// columns: kind test idx_or_ptr angle re im cos sin, all hex, parts in two's complement
// kind 00 load, 01 read, 02 read with no idle gap, 03 load on the same edge as the next read, ff end
// loads in natural order, index i holds re 1fff00i0 and im 000i3c3c
00 1 0 00 1fff0000 00003c3c 0000 0000
00 1 1 00 1fff0010 00013c3c 0000 0000
00 1 2 00 1fff0020 00023c3c 0000 0000
00 1 3 00 1fff0030 00033c3c 0000 0000
00 1 4 00 1fff0040 00043c3c 0000 0000
00 1 5 00 1fff0050 00053c3c 0000 0000
00 1 6 00 1fff0060 00063c3c 0000 0000
00 1 7 00 1fff0070 00073c3c 0000 0000
00 1 8 00 1fff0080 00083c3c 0000 0000
00 1 9 00 1fff0090 00093c3c 0000 0000
00 1 a 00 1fff00a0 000a3c3c 0000 0000
00 1 b 00 1fff00b0 000b3c3c 0000 0000
00 1 c 00 1fff00c0 000c3c3c 0000 0000
00 1 d 00 1fff00d0 000d3c3c 0000 0000
00 1 e 00 1fff00e0 000e3c3c 0000 0000
00 1 f 00 1fff00f0 000f3c3c 0000 0000
// storage order reads, address a holds index bitrev(a)
01 2 0 08 1fff0000 00003c3c 0fb1 3ce1
01 2 1 10 1fff0080 00083c3c 0ec8 39e1
01 2 2 18 1fff0040 00043c3c 0d4e 371c
01 2 3 20 1fff00c0 000c3c3c 0b50 34b0
01 2 4 28 1fff0020 00023c3c 08e4 32b2
01 2 5 30 1fff00a0 000a3c3c 061f 3138
01 2 6 38 1fff0060 00063c3c 031f 304f
01 2 7 48 1fff00e0 000e3c3c 3ce1 304f
01 2 8 50 1fff0010 00013c3c 39e1 3138
01 2 9 58 1fff0090 00093c3c 371c 32b2
01 2 a 68 1fff0050 00053c3c 32b2 371c
01 2 b 70 1fff00d0 000d3c3c 3138 39e1
01 2 c 78 1fff0030 00033c3c 304f 3ce1
01 2 d 00 1fff00b0 000b3c3c 1000 0000
01 2 e 40 1fff0070 00073c3c 0000 3000
01 2 f 60 1fff00f0 000f3c3c 34b0 34b0
// fold points, both quadrants
01 3 5 00 1fff00a0 000a3c3c 1000 0000
01 3 a 01 1fff0050 00053c3c 0fff 3f9b
01 3 3 20 1fff00c0 000c3c3c 0b50 34b0
01 3 c 3f 1fff0030 00033c3c 0065 3001
01 3 0 40 1fff0000 00003c3c 0000 3000
01 3 f 41 1fff00f0 000f3c3c 3f9b 3001
01 3 9 60 1fff0090 00093c3c 34b0 34b0
01 3 6 7f 1fff0060 00063c3c 3001 3f9b
// one strobe per cycle
01 4 f 7f 1fff00f0 000f3c3c 3001 3f9b
02 4 e 78 1fff0070 00073c3c 304f 3ce1
02 4 d 70 1fff00b0 000b3c3c 3138 39e1
02 4 c 68 1fff0030 00033c3c 32b2 371c
02 4 b 60 1fff00d0 000d3c3c 34b0 34b0
02 4 a 58 1fff0050 00053c3c 371c 32b2
02 4 9 50 1fff0090 00093c3c 39e1 3138
02 4 8 48 1fff0010 00013c3c 3ce1 304f
02 4 7 41 1fff00e0 000e3c3c 3f9b 3001
02 4 6 40 1fff0060 00063c3c 0000 3000
// overwrite index 3 at address c while reading it
01 5 c 01 1fff0030 00033c3c 0fff 3f9b
03 5 3 00 0fffffff 10000000 0000 0000
02 5 c 20 1fff0030 00033c3c 0b50 34b0
02 5 c 3f 0fffffff 10000000 0065 3001
01 5 3 41 1fff00c0 000c3c3c 3f9b 3001
// index 8 lands at address 1
03 5 8 00 00000001 1fffffff 0000 0000
02 5 1 10 1fff0080 00083c3c 0ec8 39e1
02 5 1 7f 00000001 1fffffff 3001 3f9b
ff 0 0 00 00000000 00000000 0000 0000

// File: dv/tb_fft_operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_mem_config.svh"

module tb_fft_operand_fetch
   import fft_sample_pkg::*;
   import fft_twiddle_pkg::*;
();

   localparam int CLK_HALF  = 4;
   localparam int RESET_CYC = 10;
   localparam int REC_W     = 8;     // hex words per trace record
   localparam int MAX_REC   = 128;

   localparam logic [7:0] KIND_LOAD      = 8'h00;
   localparam logic [7:0] KIND_READ      = 8'h01;
   localparam logic [7:0] KIND_READ_B2B  = 8'h02;   // no idle gap before it
   localparam logic [7:0] KIND_LOAD_PAIR = 8'h03;   // same cycle as the next read
   localparam logic [7:0] KIND_END       = 8'hff;

   logic                   clk;
   logic                   reset;
   logic                   load;
   load_req_t              load_req;
   logic                   rd_en;
   logic [`FFT_ADDR_W-1:0] rd_ptr;
   angle_idx_t             rd_angle;
   cplx_sample_t           sample_out;
   twiddle_t               twiddle_out;
   logic                   radix_valid;

   logic                   exp_push;
   logic [7:0]             exp_test;
   cplx_sample_t           exp_sample;
   twiddle_t               exp_twiddle;
   int                     value_errs;
   int                     pulse_errs;
   int                     checks_done;

   logic [31:0]            trace_mem [REC_W*MAX_REC];
   int                     num_recs;
   int                     reads_issued;
   int                     other_errs;
   logic                   trace_ok;
   integer                 seed;

   fft_operand_fetch DUT (
      .clk         (clk),
      .reset       (reset),
      .load        (load),
      .load_req    (load_req),
      .rd_en       (rd_en),
      .rd_ptr      (rd_ptr),
      .rd_angle    (rd_angle),
      .sample_out  (sample_out),
      .twiddle_out (twiddle_out),
      .radix_valid (radix_valid)
   );

   fetch_checker u_checker (
      .clk         (clk),
      .reset       (reset),
      .exp_push    (exp_push),
      .exp_test    (exp_test),
      .exp_sample  (exp_sample),
      .exp_twiddle (exp_twiddle),
      .sample_out  (sample_out),
      .twiddle_out (twiddle_out),
      .radix_valid (radix_valid),
      .value_errs  (value_errs),
      .pulse_errs  (pulse_errs),
      .checks_done (checks_done)
   );

   bind fft_operand_fetch fetch_props u_props (
      .clk         (clk),
      .reset       (reset),
      .rd_en       (rd_en),
      .radix_valid (radix_valid),
      .sample_out  (sample_out),
      .twiddle_out (twiddle_out)
   );

   initial clk = 1'b0;
   always #CLK_HALF clk = ~clk;

   task automatic next_slot();
      @(posedge clk);
      #1;
   endtask

   task automatic clear_strobes();
      load     = 1'b0;
      rd_en    = 1'b0;
      exp_push = 1'b0;
      rd_ptr   = ~rd_ptr;     // address lines move while idle, outputs must not
      rd_angle = ~rd_angle;
   endtask

   task automatic apply_record(input int r);
      int base;
      base = r * REC_W;
      case (trace_mem[base][7:0])
         KIND_LOAD, KIND_LOAD_PAIR: begin
            load               = 1'b1;
            load_req.idx       = trace_mem[base+2][`FFT_ADDR_W-1:0];
            load_req.sample.re = trace_mem[base+4][`FFT_SAMPLE_W-1:0];
            load_req.sample.im = trace_mem[base+5][`FFT_SAMPLE_W-1:0];
         end
         KIND_READ, KIND_READ_B2B: begin
            rd_en           = 1'b1;
            rd_ptr          = trace_mem[base+2][`FFT_ADDR_W-1:0];
            rd_angle        = trace_mem[base+3][`TW_ANGLE_W-1:0];
            exp_push        = 1'b1;
            exp_test        = trace_mem[base+1][7:0];
            exp_sample.re   = trace_mem[base+4][`FFT_SAMPLE_W-1:0];
            exp_sample.im   = trace_mem[base+5][`FFT_SAMPLE_W-1:0];
            exp_twiddle.cos = trace_mem[base+6][`TW_W-1:0];
            exp_twiddle.sin = trace_mem[base+7][`TW_W-1:0];
            reads_issued++;
         end
         default: begin
            other_errs++;
            $display("trace record %0d has an unknown kind %h", r, trace_mem[base]);
         end
      endcase
   endtask

   task automatic count_records();
      logic [31:0] kind;
      bit          done;
      done     = 1'b0;
      num_recs = 0;
      kind     = 'x;
      while (!done && num_recs < MAX_REC) begin
         kind = trace_mem[num_recs*REC_W];
         if (kind === {24'h0, KIND_END} || $isunknown(kind)) begin
            done = 1'b1;
         end else begin
            num_recs++;
         end
      end
      trace_ok = (kind === {24'h0, KIND_END});
   endtask

   task automatic run_trace();
      int         r;
      int         gap;
      logic [7:0] kind;
      r = 0;
      while (r < num_recs) begin
         kind = trace_mem[r*REC_W][7:0];
         gap  = (kind == KIND_READ_B2B) ? 0 : $unsigned($random(seed)) % 4;
         repeat (gap) begin
            next_slot();
            clear_strobes();
         end
         next_slot();
         clear_strobes();
         apply_record(r);
         if (kind == KIND_LOAD_PAIR) begin
            r++;
            apply_record(r);   // read strobed on the write edge
         end
         r++;
      end
      next_slot();
      clear_strobes();
   endtask

   task automatic report_and_finish();
      int assert_errs;
      int total;
      assert_errs = DUT.u_props.fail_count;
      if (reads_issued != checks_done) begin
         other_errs++;
         $display("%0d reads were strobed but %0d results were checked",
                  reads_issued, checks_done);
      end
      total = value_errs + pulse_errs + assert_errs + other_errs;
      $display("errors: value %0d, pulse %0d, assertion %0d, other %0d",
               value_errs, pulse_errs, assert_errs, other_errs);
      if (total == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   endtask

   initial begin
      reset        = 1'b1;
      load         = 1'b0;
      load_req     = '0;
      rd_en        = 1'b1;   // strobe through early reset, valid must stay low
      rd_ptr       = '0;
      rd_angle     = '0;
      exp_push     = 1'b0;
      exp_test     = '0;
      exp_sample   = '0;
      exp_twiddle  = '0;
      reads_issued = 0;
      other_errs   = 0;
      trace_ok     = 1'b0;
      seed         = 32876;
      $readmemh("dv/fetch_trace.txt", trace_mem);
      count_records();
      if (!trace_ok) begin
         $display("trace file dv/fetch_trace.txt is missing or has no end record");
         $display("CHECKS FAILED");
         $finish;
      end else begin
         repeat (RESET_CYC - 1) @(posedge clk);
         #1;
         rd_en = 1'b0;
         @(posedge clk);
         #1;
         reset = 1'b0;
         run_trace();
         repeat (3) @(posedge clk);
         #1;
         report_and_finish();
      end
   end

   // at most 3 idle cycles plus one strobe per record
   initial begin
      wait (trace_ok === 1'b1);
      repeat (num_recs * 5 + 50) @(posedge clk);
      $display("watchdog expired after %0d cycles before the trace finished",
               num_recs * 5 + 50);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/fft_mem_config.svh
`ifndef FFT_MEM_CONFIG_SVH
`define FFT_MEM_CONFIG_SVH

// sample buffer geometry
`define FFT_SAMPLE_W 29   // bits per real or imag part
`define FFT_POINTS   16   // complex samples held
`define FFT_ADDR_W   4    // log2 of point count

// twiddle table geometry
`define TW_W         14   // bits per cos or sin part
`define TW_ANGLE_W   7    // steps of pi/128 over half a turn

// fixed point unity in Q1.12
`define TW_ONE       4096

`endif

// File: hdl/fft_operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_mem_config.svh"

module fft_operand_fetch
   import fft_sample_pkg::*;
   import fft_twiddle_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   load,
   input  wire load_req_t              load_req,
   input  wire logic                   rd_en,
   input  wire logic [`FFT_ADDR_W-1:0] rd_ptr,
   input  wire angle_idx_t             rd_angle,
   output cplx_sample_t                sample_out,
   output twiddle_t                    twiddle_out,
   output logic                        radix_valid
);

   // data operand, read in storage order
   sample_buffer u_sample_buffer (
      .clk      (clk),
      .load     (load),
      .load_req (load_req),
      .rd_en    (rd_en),
      .rd_ptr   (rd_ptr),
      .rd_data  (sample_out)
   );

   // twiddle fetched on the same strobe
   twiddle_rom u_twiddle_rom (
      .clk     (clk),
      .rd_en   (rd_en),
      .angle   (rd_angle),
      .twiddle (twiddle_out)
   );

   // lines up with both registered read ports
   always_ff @(posedge clk) begin
      if (reset) begin
         radix_valid <= 1'b0;
      end else begin
         radix_valid <= rd_en;
      end
   end

endmodule

`default_nettype wire

// File: hdl/fft_sample_pkg.sv
`default_nettype none

`include "fft_mem_config.svh"

package fft_sample_pkg;

   // one complex operand, real part in the upper bits
   typedef struct packed {
      logic signed [`FFT_SAMPLE_W-1:0] re;
      logic signed [`FFT_SAMPLE_W-1:0] im;
   } cplx_sample_t;

   // storage word, raw for the array and complex for the ports
   typedef union packed {
      logic [2*`FFT_SAMPLE_W-1:0] raw;
      cplx_sample_t               cplx;
   } sample_word_u;

   // loader side request, index in natural order
   typedef struct packed {
      logic [`FFT_ADDR_W-1:0] idx;
      cplx_sample_t           sample;
   } load_req_t;

endpackage

`default_nettype wire

// File: hdl/fft_twiddle_pkg.sv
`default_nettype none

`include "fft_mem_config.svh"

package fft_twiddle_pkg;

   // W = cos - j*sin, sin part already carries its minus sign
   typedef struct packed {
      logic signed [`TW_W-1:0] cos;
      logic signed [`TW_W-1:0] sin;
   } twiddle_t;

   // angle in steps of pi/128
   typedef logic [`TW_ANGLE_W-1:0] angle_idx_t;

endpackage

`default_nettype wire

// File: hdl/sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_mem_config.svh"

module sample_buffer
   import fft_sample_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   load,
   input  wire load_req_t              load_req,
   input  wire logic                   rd_en,
   input  wire logic [`FFT_ADDR_W-1:0] rd_ptr,
   output cplx_sample_t                rd_data
);

   sample_word_u           mem [`FFT_POINTS];
   sample_word_u           wr_word;
   sample_word_u           rd_word;   // registered read port
   logic [`FFT_ADDR_W-1:0] wr_addr;

   // mirror the index bits, natural order in, bit-reversed storage
   always_comb begin
      for (int i = 0; i < `FFT_ADDR_W; i++) begin
         wr_addr[i] = load_req.idx[`FFT_ADDR_W-1-i];
      end
   end

   assign wr_word.cplx = load_req.sample;

   always_ff @(posedge clk) begin
      if (load) begin
         mem[wr_addr].raw <= wr_word.raw;
      end
      if (rd_en) begin
         rd_word.raw <= mem[rd_ptr].raw;   // old data on a same-edge write
      end
   end

   assign rd_data = rd_word.cplx;   // held between strobes

endmodule

`default_nettype wire

// File: hdl/twiddle_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "fft_mem_config.svh"

module twiddle_rom
   import fft_twiddle_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rd_en,
   input  wire angle_idx_t angle,
   output twiddle_t        twiddle
);

   // pi/2 in angle steps, the fold point
   localparam angle_idx_t QUARTER = angle_idx_t'(1 << (`TW_ANGLE_W - 1));

   logic [`TW_ANGLE_W-1:0] cos_idx;
   logic [`TW_ANGLE_W-1:0] sin_idx;
   logic                   cos_neg;
   logic [`TW_W-1:0]       cos_mag;
   logic [`TW_W-1:0]       sin_mag;
   twiddle_t               tw_next;

   // round(4096 * sin(j*pi/128)), first quadrant only
   function automatic logic [`TW_W-1:0] quarter_sin(input logic [`TW_ANGLE_W-1:0] j);
      case (j)
         0:  quarter_sin = `TW_W'd0;
         1:  quarter_sin = `TW_W'd101;
         2:  quarter_sin = `TW_W'd201;
         3:  quarter_sin = `TW_W'd301;
         4:  quarter_sin = `TW_W'd401;
         5:  quarter_sin = `TW_W'd501;
         6:  quarter_sin = `TW_W'd601;
         7:  quarter_sin = `TW_W'd700;
         8:  quarter_sin = `TW_W'd799;
         9:  quarter_sin = `TW_W'd897;
         10: quarter_sin = `TW_W'd995;
         11: quarter_sin = `TW_W'd1092;
         12: quarter_sin = `TW_W'd1189;
         13: quarter_sin = `TW_W'd1285;
         14: quarter_sin = `TW_W'd1380;
         15: quarter_sin = `TW_W'd1474;
         16: quarter_sin = `TW_W'd1567;
         17: quarter_sin = `TW_W'd1660;
         18: quarter_sin = `TW_W'd1751;
         19: quarter_sin = `TW_W'd1842;
         20: quarter_sin = `TW_W'd1931;
         21: quarter_sin = `TW_W'd2019;
         22: quarter_sin = `TW_W'd2106;
         23: quarter_sin = `TW_W'd2191;
         24: quarter_sin = `TW_W'd2276;
         25: quarter_sin = `TW_W'd2359;
         26: quarter_sin = `TW_W'd2440;
         27: quarter_sin = `TW_W'd2520;
         28: quarter_sin = `TW_W'd2598;
         29: quarter_sin = `TW_W'd2675;
         30: quarter_sin = `TW_W'd2751;
         31: quarter_sin = `TW_W'd2824;
         32: quarter_sin = `TW_W'd2896;   // pi/4
         33: quarter_sin = `TW_W'd2967;
         34: quarter_sin = `TW_W'd3035;
         35: quarter_sin = `TW_W'd3102;
         36: quarter_sin = `TW_W'd3166;
         37: quarter_sin = `TW_W'd3229;
         38: quarter_sin = `TW_W'd3290;
         39: quarter_sin = `TW_W'd3349;
         40: quarter_sin = `TW_W'd3406;
         41: quarter_sin = `TW_W'd3461;
         42: quarter_sin = `TW_W'd3513;
         43: quarter_sin = `TW_W'd3564;
         44: quarter_sin = `TW_W'd3612;
         45: quarter_sin = `TW_W'd3659;
         46: quarter_sin = `TW_W'd3703;
         47: quarter_sin = `TW_W'd3745;
         48: quarter_sin = `TW_W'd3784;
         49: quarter_sin = `TW_W'd3822;
         50: quarter_sin = `TW_W'd3857;
         51: quarter_sin = `TW_W'd3889;
         52: quarter_sin = `TW_W'd3920;
         53: quarter_sin = `TW_W'd3948;
         54: quarter_sin = `TW_W'd3973;
         55: quarter_sin = `TW_W'd3996;
         56: quarter_sin = `TW_W'd4017;
         57: quarter_sin = `TW_W'd4036;
         58: quarter_sin = `TW_W'd4052;
         59: quarter_sin = `TW_W'd4065;
         60: quarter_sin = `TW_W'd4076;
         61: quarter_sin = `TW_W'd4085;
         62: quarter_sin = `TW_W'd4091;
         63: quarter_sin = `TW_W'd4095;
         64: quarter_sin = `TW_W'(`TW_ONE);   // exact unity at pi/2
         default: quarter_sin = `TW_W'd0;     // folding never reaches here
      endcase
   endfunction

   // fold the half turn onto the quarter table
   always_comb begin
      if (angle <= QUARTER) begin
         cos_idx = QUARTER - angle;
         sin_idx = angle;
         cos_neg = 1'b0;
      end else begin
         cos_idx = angle - QUARTER;
         sin_idx = -angle;   // 128 - k, wraps in 7 bits
         cos_neg = 1'b1;     // second quadrant
      end
   end

   assign cos_mag = quarter_sin(cos_idx);
   assign sin_mag = quarter_sin(sin_idx);

   assign tw_next.cos = cos_neg ? -cos_mag : cos_mag;
   assign tw_next.sin = -sin_mag;   // sin is never positive on a half turn

   always_ff @(posedge clk) begin
      if (rd_en) begin
         twiddle <= tw_next;
      end
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/fft_sample_pkg.sv
hdl/fft_twiddle_pkg.sv
hdl/sample_buffer.sv
hdl/twiddle_rom.sv
hdl/fft_operand_fetch.sv
dv/fetch_props.sv
dv/fetch_checker.sv
dv/tb_fft_operand_fetch.sv
